// File: design/spi_cfg_pkg.sv
// spi timing configuration definitions
// register map, config write bus and calculator widths
package spi_cfg_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   localparam int CFG_ADDR_W = 2;   // config address
   localparam int CALC_W     = 32;  // m, x, b and y
   localparam int HALF_W     = 16;  // half-period, low bits of y

   ////////////////////////////////////////////////////////////
   // register map
   localparam logic [CFG_ADDR_W-1:0] ADDR_SLOPE  = 2'd0;  // m
   localparam logic [CFG_ADDR_W-1:0] ADDR_SPEED  = 2'd1;  // x, also iteration count
   localparam logic [CFG_ADDR_W-1:0] ADDR_OFFSET = 2'd2;  // b
   // address 3 is unused, writes there fall on the floor

   // reset values
   localparam logic [CALC_W-1:0] RST_SLOPE  = 32'd0;
   localparam logic [CALC_W-1:0] RST_SPEED  = 32'd0;
   localparam logic [CALC_W-1:0] RST_OFFSET = 32'd4;

   // half-period published straight out of reset, m*x+b of the above
   localparam logic [HALF_W-1:0] RST_HALF =
      HALF_W'(RST_SLOPE * RST_SPEED + RST_OFFSET);

   ////////////////////////////////////////////////////////////
   // config write, 35 bits
   typedef struct packed {
      logic                  en;    // write enable
      logic [CFG_ADDR_W-1:0] addr;  // register select
      logic [CALC_W-1:0]     data;  // write data
   } cfg_wr_t;

endpackage

// File: design/spi_xfer_pkg.sv
// spi transfer definitions
// command and response words plus credit sizing
package spi_xfer_pkg;

   ////////////////////////////////////////////////////////////
   // frame and credit sizes
   localparam int FRAME_W     = 8;  // bits per frame
   localparam int CMD_DEPTH   = 4;  // cmd fifo depth = sender credits
   localparam int RSP_CREDITS = 2;  // rsp credits held after reset

   // derived counter widths
   localparam int CMD_PTR_W = $clog2(CMD_DEPTH);       // fifo pointers
   localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);   // fifo fill, 0..depth
   localparam int RSP_CNT_W = $clog2(RSP_CREDITS + 1); // 0..RSP_CREDITS
   localparam int BIT_CNT_W = $clog2(FRAME_W);         // bit index in frame

   ////////////////////////////////////////////////////////////
   // command, 9 bits
   typedef struct packed {
      logic [FRAME_W-1:0] tx;    // byte to shift out, msb first
      logic               last;  // raise cs after this frame
   } spi_cmd_t;

   // response, 8 bits
   typedef struct packed {
      logic [FRAME_W-1:0] rx;    // byte shifted in from miso
   } spi_rsp_t;

endpackage

// File: design/lin_calc.sv
`timescale 1ns/1ps
// iterative linear calculator, y = m*x + b
// adds m once per cycle for x cycles, so no multiplier is built
// overflow wraps silently
module lin_calc (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           i_start,  // launch a new sum
   input  logic [spi_cfg_pkg::CALC_W-1:0] i_m,      // slope
   input  logic [spi_cfg_pkg::CALC_W-1:0] i_x,      // abscissa, iteration count
   input  logic [spi_cfg_pkg::CALC_W-1:0] i_b,      // intercept
   output logic [spi_cfg_pkg::CALC_W-1:0] o_y,      // result, valid with o_done
   output logic                           o_done,   // one cycle pulse
   output logic                           o_busy
);
   import spi_cfg_pkg::*;

   typedef enum logic {S_IDLE, S_CALC} state_t;

   state_t            state;
   logic [CALC_W-1:0] m_q;   // captured slope
   logic [CALC_W-1:0] x_q;   // captured count
   logic [CALC_W-1:0] acc;   // running m*i
   logic [CALC_W-1:0] cnt;   // additions done so far

   ////////////////////////////////////////////////////////////
   // control
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= S_IDLE;
         o_done <= 1'b0;
      end
      else
      begin
         o_done <= 1'b0;  // pulse by default low
         case (state)
            S_IDLE:
            begin
               if (i_start)
                  state <= S_CALC;  // one setup cycle spent here
            end
            S_CALC:
            begin
               if (cnt == x_q)
               begin
                  state  <= S_IDLE;
                  o_done <= 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // datapath
   always_ff @(posedge clk)
   begin
      if (state == S_IDLE && i_start)
      begin
         m_q <= i_m;
         x_q <= i_x;
         acc <= '0;
         cnt <= '0;
      end
      else if (state == S_CALC)
      begin
         if (cnt == x_q)
            o_y <= acc + i_b;  // x == 0 lands here first, y = b
         else
         begin
            acc <= acc + m_q;
            cnt <= cnt + CALC_W'(1);
         end
      end
   end

   assign o_busy = (state == S_CALC);

endmodule

// File: design/spi_cfg_regs.sv
`timescale 1ns/1ps
// spi timing registers
// slope, speed and offset feed lin_calc; the settled sum becomes
// the sclk half-period, flagged by o_ready
module spi_cfg_regs (
   input  logic                           clk,
   input  logic                           rst,
   input  spi_cfg_pkg::cfg_wr_t           i_cfg,
   output logic [spi_cfg_pkg::HALF_W-1:0] o_half,   // sclk half-period in clk
   output logic                           o_ready   // o_half matches the regs
);
   import spi_cfg_pkg::*;

   logic [CALC_W-1:0] slope;   // m
   logic [CALC_W-1:0] speed;   // x
   logic [CALC_W-1:0] offset;  // b
   logic              wr_hit;  // write landing in a real register
   logic              pend;    // start owed to the calculator
   logic              calc_start;
   logic              calc_done;
   logic              calc_busy;
   logic [CALC_W-1:0] calc_y;

   assign wr_hit = i_cfg.en &&
                   (i_cfg.addr == ADDR_SLOPE ||
                    i_cfg.addr == ADDR_SPEED ||
                    i_cfg.addr == ADDR_OFFSET);

   ////////////////////////////////////////////////////////////
   // register file
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         slope  <= RST_SLOPE;
         speed  <= RST_SPEED;
         offset <= RST_OFFSET;
      end
      else if (i_cfg.en)
      begin
         case (i_cfg.addr)
            ADDR_SLOPE:  slope  <= i_cfg.data;
            ADDR_SPEED:  speed  <= i_cfg.data;
            ADDR_OFFSET: offset <= i_cfg.data;
            default:     ;  // reserved slot
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // restart tracking
   // a start waits here while the calculator is still busy
   assign calc_start = pend && !calc_busy;

   always_ff @(posedge clk)
   begin
      if (rst)
         pend <= 1'b0;
      else if (wr_hit)
         pend <= 1'b1;  // wins over a start issued this cycle
      else if (calc_start)
         pend <= 1'b0;
   end

   // publish only a sum that answers the newest values
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         o_half  <= RST_HALF;
         o_ready <= 1'b1;
      end
      else if (wr_hit)
         o_ready <= 1'b0;
      else if (calc_done && !pend)
      begin
         o_half  <= calc_y[HALF_W-1:0];  // upper bits dropped
         o_ready <= 1'b1;
      end
   end

   lin_calc u_calc (
      .clk     (clk),
      .rst     (rst),
      .i_start (calc_start),
      .i_m     (slope),
      .i_x     (speed),
      .i_b     (offset),
      .o_y     (calc_y),
      .o_done  (calc_done),
      .o_busy  (calc_busy)
   );

endmodule

// File: design/spi_shift_engine.sv
`timescale 1ns/1ps
// spi mode 0 shift engine
// credit-fed command fifo in, credit-gated responses out,
// 8 bit frames msb first with cs held low until a last frame
module spi_shift_engine (
   input  logic                           clk,
   input  logic                           rst,
   input  spi_xfer_pkg::spi_cmd_t         i_cmd,
   input  logic                           i_cmd_valid,   // sender holds a credit
   output logic                           o_cmd_credit,  // one per fifo pop
   output spi_xfer_pkg::spi_rsp_t         o_rsp,
   output logic                           o_rsp_valid,
   input  logic                           i_rsp_credit,  // receiver returns one
   input  logic [spi_cfg_pkg::HALF_W-1:0] i_half,
   input  logic                           i_ready,
   output logic                           o_sclk,
   output logic                           o_mosi,
   output logic                           o_cs_n,
   input  logic                           i_miso
);
   import spi_cfg_pkg::*;
   import spi_xfer_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_SETUP, S_LOW, S_HIGH} state_t;

   spi_cmd_t             fifo_mem [CMD_DEPTH];
   logic [CMD_PTR_W-1:0] wr_ptr;
   logic [CMD_PTR_W-1:0] rd_ptr;
   logic [CMD_CNT_W-1:0] fifo_cnt;
   logic [RSP_CNT_W-1:0] rsp_cred;   // frames we may still start
   state_t               state;
   logic [HALF_W-1:0]    h_eff;      // i_half with 0 read as 1
   logic [HALF_W-1:0]    h_q;        // half-period for this frame
   logic [HALF_W-1:0]    hcnt;       // cycles left in phase, minus one
   logic [BIT_CNT_W-1:0] bit_cnt;
   logic [FRAME_W-1:0]   shreg;      // tx out the top, rx in the bottom
   logic                 last_q;     // frame closes the cs window
   logic                 pop;
   logic                 phase_end;
   logic                 frame_end;

   ////////////////////////////////////////////////////////////
   // command fifo
   // no full check, the sender's credits keep it from overflowing
   always_ff @(posedge clk)
   begin
      if (i_cmd_valid)
         fifo_mem[wr_ptr] <= i_cmd;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_cnt <= '0;
      end
      else
      begin
         if (i_cmd_valid)
            wr_ptr <= wr_ptr + CMD_PTR_W'(1);
         if (pop)
            rd_ptr <= rd_ptr + CMD_PTR_W'(1);
         case ({i_cmd_valid, pop})
            2'b10:   fifo_cnt <= fifo_cnt + CMD_CNT_W'(1);
            2'b01:   fifo_cnt <= fifo_cnt - CMD_CNT_W'(1);
            default: ;  // both or neither, fill unchanged
         endcase
      end
   end

   // frame start needs a command, a response slot and settled timing
   assign pop          = (state == S_IDLE) && (fifo_cnt != '0) &&
                         (rsp_cred != '0) && i_ready;
   assign o_cmd_credit = pop;  // slot freed the same cycle

   ////////////////////////////////////////////////////////////
   // response credits
   always_ff @(posedge clk)
   begin
      if (rst)
         rsp_cred <= RSP_CNT_W'(RSP_CREDITS);
      else
      begin
         case ({pop, i_rsp_credit})
            2'b10:   rsp_cred <= rsp_cred - RSP_CNT_W'(1);
            2'b01:   rsp_cred <= rsp_cred + RSP_CNT_W'(1);
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // sclk sequencing
   assign h_eff     = (i_half == '0) ? HALF_W'(1) : i_half;
   assign phase_end = (hcnt == '0);
   assign frame_end = (state == S_HIGH) && phase_end &&
                      (bit_cnt == BIT_CNT_W'(FRAME_W - 1));

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= S_IDLE;
         o_cs_n      <= 1'b1;
         o_sclk      <= 1'b0;
         o_mosi      <= 1'b0;
         o_rsp_valid <= 1'b0;
         hcnt        <= '0;
         bit_cnt     <= '0;
      end
      else
      begin
         o_rsp_valid <= 1'b0;
         case (state)
            S_IDLE:
            begin
               if (pop)
               begin
                  o_cs_n  <= 1'b0;  // no change if already low
                  o_mosi  <= fifo_mem[rd_ptr].tx[FRAME_W-1];
                  hcnt    <= h_eff - HALF_W'(1);
                  bit_cnt <= '0;
                  state   <= S_SETUP;
               end
            end
            S_SETUP:  // cs low, sclk low, first bit on mosi
            begin
               hcnt <= phase_end ? h_q - HALF_W'(1) : hcnt - HALF_W'(1);
               if (phase_end)
                  state <= S_LOW;
            end
            S_LOW:
            begin
               hcnt <= phase_end ? h_q - HALF_W'(1) : hcnt - HALF_W'(1);
               if (phase_end)
               begin
                  o_sclk <= 1'b1;  // rising edge, miso sampled below
                  state  <= S_HIGH;
               end
            end
            S_HIGH:
            begin
               hcnt <= phase_end ? h_q - HALF_W'(1) : hcnt - HALF_W'(1);
               if (phase_end)
               begin
                  o_sclk <= 1'b0;
                  if (frame_end)
                  begin
                     o_rsp_valid <= 1'b1;
                     if (last_q)
                        o_cs_n <= 1'b1;
                     state <= S_IDLE;
                  end
                  else
                  begin
                     bit_cnt <= bit_cnt + BIT_CNT_W'(1);
                     o_mosi  <= shreg[FRAME_W-1];  // next bit on falling edge
                     state   <= S_LOW;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // frame datapath
   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         shreg  <= fifo_mem[rd_ptr].tx;
         last_q <= fifo_mem[rd_ptr].last;
         h_q    <= h_eff;  // fixed for the whole frame
      end
      else if (state == S_LOW && phase_end)
         shreg <= {shreg[FRAME_W-2:0], i_miso};
      if (frame_end)
         o_rsp.rx <= shreg;
   end

endmodule

// File: design/spi_master_top.sv
`timescale 1ns/1ps
// spi master top level
// timing registers and calculator drive the shift engine's sclk rate
module spi_master_top (
   input  logic                   clk,
   input  logic                   rst,
   // configuration
   input  spi_cfg_pkg::cfg_wr_t   i_cfg,
   // commands in
   input  spi_xfer_pkg::spi_cmd_t i_cmd,
   input  logic                   i_cmd_valid,
   output logic                   o_cmd_credit,
   // responses out
   output spi_xfer_pkg::spi_rsp_t o_rsp,
   output logic                   o_rsp_valid,
   input  logic                   i_rsp_credit,
   // spi pins
   output logic                   o_sclk,
   output logic                   o_mosi,
   output logic                   o_cs_n,
   input  logic                   i_miso
);
   import spi_cfg_pkg::*;

   logic [HALF_W-1:0] half;   // published half-period
   logic              ready;  // half matches the registers

   spi_cfg_regs u_regs (
      .clk     (clk),
      .rst     (rst),
      .i_cfg   (i_cfg),
      .o_half  (half),
      .o_ready (ready)
   );

   spi_shift_engine u_engine (
      .clk          (clk),
      .rst          (rst),
      .i_cmd        (i_cmd),
      .i_cmd_valid  (i_cmd_valid),
      .o_cmd_credit (o_cmd_credit),
      .o_rsp        (o_rsp),
      .o_rsp_valid  (o_rsp_valid),
      .i_rsp_credit (i_rsp_credit),
      .i_half       (half),
      .i_ready      (ready),
      .o_sclk       (o_sclk),
      .o_mosi       (o_mosi),
      .o_cs_n       (o_cs_n),
      .i_miso       (i_miso)
   );

endmodule

// File: sim/spi_master_checker.sv
`timescale 1ns/1ps
// shift engine assertions
// bound into every spi_shift_engine instance
module spi_master_checker (
   input logic                                clk,
   input logic                                rst,
   input logic                                i_cs_n,
   input logic                                i_sclk,
   input logic                                i_cmd_valid,
   input logic                                i_cmd_credit,
   input logic [spi_xfer_pkg::RSP_CNT_W-1:0]  i_rsp_cred
);
   import spi_xfer_pkg::*;

   int occ;  // commands pushed minus credits returned

   always_ff @(posedge clk)
   begin
      if (rst)
         occ <= 0;
      else
         occ <= occ + int'(i_cmd_valid) - int'(i_cmd_credit);
   end

   // sclk only toggles inside a cs window
   a_cs_sclk: assert property (@(posedge clk) disable iff (rst) i_cs_n |-> !i_sclk)
      else $error("sclk high while chip select is deasserted");

   a_rsp_cred: assert property (@(posedge clk) disable iff (rst)
      i_rsp_cred <= RSP_CNT_W'(RSP_CREDITS))
      else $error("response credit count above its reset value");

   // credit only for a command pushed on an earlier cycle
   a_pop_fill: assert property (@(posedge clk) disable iff (rst)
      i_cmd_credit |-> (occ > 0))
      else $error("command credit returned with an empty fifo");

endmodule

bind spi_shift_engine spi_master_checker u_checker (
   .clk          (clk),
   .rst          (rst),
   .i_cs_n       (o_cs_n),
   .i_sclk       (o_sclk),
   .i_cmd_valid  (i_cmd_valid),
   .i_cmd_credit (o_cmd_credit),
   .i_rsp_cred   (rsp_cred)
);

// File: sim/spi_master_monitor.sv
`timescale 1ns/1ps
// spi master monitor
// loopback slave, sclk phase timing and byte / credit comparison
module spi_master_monitor (
   input  logic                           clk,
   input  logic                           rst,
   input  spi_xfer_pkg::spi_cmd_t         i_cmd,
   input  logic                           i_cmd_valid,
   input  logic                           i_cmd_credit,
   input  spi_xfer_pkg::spi_rsp_t         i_rsp,
   input  logic                           i_rsp_valid,
   input  logic                           i_rsp_credit,
   input  logic                           i_sclk,
   input  logic                           i_mosi,
   input  logic                           i_cs_n,
   output logic                           o_miso = 1'b0,
   input  logic [spi_cfg_pkg::HALF_W-1:0] i_exp_half,  // expected phase length
   input  logic                           i_end,       // stimulus finished
   output int                             o_err_cnt,
   output int                             o_chk_cnt,
   output int                             o_rsp_cnt
);
   import spi_xfer_pkg::*;

   logic [FRAME_W-1:0] tx_q[$];    // sent but not yet seen on mosi
   logic               last_q[$];
   logic [FRAME_W-1:0] done_q[$];  // seen on mosi with response owed
   logic               done_last_q[$];
   logic [FRAME_W-1:0] mosi_byte;
   logic [FRAME_W-1:0] exp_b;
   logic               exp_l;
   logic               sclk_d;
   logic               end_d;
   int high_cnt, low_cnt, bit_n;
   int cmd_n, credit_n, rsp_n, rcred_n, errs, checks;

   // slave model echoes ~mosi half a clock later
   always @(negedge clk)
      o_miso <= ~i_mosi;

   task automatic check(input bit ok, input string msg);
      checks++;
      if (!ok)
      begin
         errs++;
         $display("error at %0t ns: %s", $time, msg);
      end
   endtask

   always @(posedge clk)
   begin
      if (rst)
      begin
         tx_q.delete();
         last_q.delete();
         done_q.delete();
         done_last_q.delete();
         sclk_d = 1'b0;
         end_d  = 1'b0;
         bit_n  = 0;
         {cmd_n, credit_n, rsp_n, rcred_n, errs, checks} = '0;
      end
      else
      begin
         ////////////////////////////////////////////////////////////
         // credit bookkeeping
         if (i_cmd_valid)
         begin
            tx_q.push_back(i_cmd.tx);
            last_q.push_back(i_cmd.last);
            cmd_n++;
         end
         if (i_cmd_credit)
         begin
            credit_n++;
            check(credit_n <= cmd_n, "more command credits than commands");
         end
         if (i_rsp_credit)
            rcred_n++;

         ////////////////////////////////////////////////////////////
         // sclk phases counted in clk samples
         if (i_sclk && !sclk_d)  // rising edge seen
         begin
            if (bit_n > 0)
               check(low_cnt == int'(i_exp_half),
                     $sformatf("low phase %0d, expected %0d", low_cnt, i_exp_half));
            mosi_byte = {mosi_byte[FRAME_W-2:0], i_mosi};
            bit_n++;
            high_cnt = 1;
            if (bit_n == FRAME_W)
            begin
               if (tx_q.size() == 0)
                  check(1'b0, "frame on mosi with no command queued");
               else
               begin
                  exp_b = tx_q.pop_front();
                  exp_l = last_q.pop_front();
                  check(mosi_byte == exp_b,
                        $sformatf("mosi %02h, expected %02h", mosi_byte, exp_b));
                  done_q.push_back(exp_b);
                  done_last_q.push_back(exp_l);
               end
            end
         end
         else if (i_sclk)
            high_cnt++;
         else if (sclk_d)  // falling edge seen
         begin
            check(high_cnt == int'(i_exp_half),
                  $sformatf("high phase %0d, expected %0d", high_cnt, i_exp_half));
            low_cnt = 1;
            if (bit_n == FRAME_W)
               bit_n = 0;
         end
         else
            low_cnt++;
         sclk_d = i_sclk;

         ////////////////////////////////////////////////////////////
         // responses
         if (i_rsp_valid)
         begin
            rsp_n++;
            check(rsp_n <= RSP_CREDITS + rcred_n, "response sent without a credit");
            if (done_q.size() == 0)
               check(1'b0, "response with no finished frame");
            else
            begin
               exp_b = done_q.pop_front();
               exp_l = done_last_q.pop_front();
               check(i_rsp.rx == ~exp_b,
                     $sformatf("rx %02h, expected %02h", i_rsp.rx, ~exp_b));
               check(i_cs_n == exp_l, $sformatf("cs_n %0b after frame, expected %0b",
                     i_cs_n, exp_l));
            end
         end

         // at end of run everything sent must have come back
         if (i_end && !end_d)
         begin
            check(tx_q.size() == 0 && done_q.size() == 0, "frames left unfinished");
            check(credit_n == cmd_n, "command credits do not match commands");
            check(rsp_n == cmd_n, "response count does not match commands");
         end
         end_d = i_end;
      end
      // counts reach the tb one clock later
      o_err_cnt <= errs;
      o_chk_cnt <= checks;
      o_rsp_cnt <= rsp_n;
   end

endmodule

// File: sim/spi_master_tb.sv
`timescale 1ns/1ps
// spi master testbench
// lfsr stimulus, credit senders, watchdog and summary
module spi_master_tb;
   import spi_cfg_pkg::*;
   import spi_xfer_pkg::*;

   localparam int MAX_H      = 69;   // 7*9+6
   localparam int FRAME_CYC  = (2 * FRAME_W + 1) * MAX_H + 24;
   localparam int NUM_FRAMES = 40;
   localparam int WD_CYCLES  = NUM_FRAMES * FRAME_CYC + 4000;

   logic clk, rst;
   cfg_wr_t  cfg;
   spi_cmd_t cmd;
   spi_rsp_t rsp;
   logic cmd_valid, cmd_credit, rsp_valid;
   logic rsp_credit = 1'b0;
   logic sclk, mosi, cs_n, miso;
   logic [HALF_W-1:0] exp_half;   // model half-period
   logic run_end;
   logic hold;                    // withhold response credits
   logic [31:0] stim_lfsr, cred_lfsr;
   logic [31:0] m_model, x_model, b_model;
   logic [7:0]  tx_b;
   logic        last_b;
   int err_cnt, chk_cnt, rsp_cnt;
   int cmd_cred, sent, owed, wait_cnt, tests, last_err, base;

   spi_master_top uut (
      .clk(clk), .rst(rst), .i_cfg(cfg),
      .i_cmd(cmd), .i_cmd_valid(cmd_valid), .o_cmd_credit(cmd_credit),
      .o_rsp(rsp), .o_rsp_valid(rsp_valid), .i_rsp_credit(rsp_credit),
      .o_sclk(sclk), .o_mosi(mosi), .o_cs_n(cs_n), .i_miso(miso)
   );

   spi_master_monitor mon (
      .clk(clk), .rst(rst), .i_cmd(cmd), .i_cmd_valid(cmd_valid),
      .i_cmd_credit(cmd_credit), .i_rsp(rsp), .i_rsp_valid(rsp_valid),
      .i_rsp_credit(rsp_credit), .i_sclk(sclk), .i_mosi(mosi), .i_cs_n(cs_n),
      .o_miso(miso), .i_exp_half(exp_half), .i_end(run_end),
      .o_err_cnt(err_cnt), .o_chk_cnt(chk_cnt), .o_rsp_cnt(rsp_cnt)
   );

   // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] lfsr_bits(inout logic [31:0] st, input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = st[31] ^ st[21] ^ st[1] ^ st[0];
         st = {st[30:0], fb};
         r  = {r[30:0], fb};
      end
      return r;
   endfunction

   // low bits of m*x+b where zero runs as one
   function automatic logic [HALF_W-1:0] expect_half(input logic [31:0] m, x, b);
      logic [31:0] y;
      y = m * x + b;
      return (y[HALF_W-1:0] == '0) ? HALF_W'(1) : y[HALF_W-1:0];
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // sender's command credits
   always @(posedge clk)
   begin
      if (rst)
         cmd_cred <= CMD_DEPTH;
      else
         cmd_cred <= cmd_cred - int'(cmd_valid) + int'(cmd_credit);
   end

   // receiver returns response credits after a random wait
   always @(posedge clk)
   begin
      if (rst)
      begin
         owed      = 0;
         wait_cnt  = 0;
         cred_lfsr = 32'h92ab_ce7f;
         rsp_credit <= 1'b0;
      end
      else
      begin
         rsp_credit <= 1'b0;
         if (rsp_valid)
            owed = owed + 1;
         if (owed > 0 && !hold)
         begin
            if (wait_cnt == 0)
            begin
               rsp_credit <= 1'b1;
               owed     = owed - 1;
               wait_cnt = int'(lfsr_bits(cred_lfsr, 3));
            end
            else
               wait_cnt = wait_cnt - 1;
         end
      end
   end

   task automatic cfg_write(input logic [CFG_ADDR_W-1:0] a, input logic [31:0] d);
      @(posedge clk);
      cfg <= '{en: 1'b1, addr: a, data: d};
      case (a)
         ADDR_SLOPE:  m_model = d;
         ADDR_SPEED:  x_model = d;
         ADDR_OFFSET: b_model = d;
         default:     ;  // unmapped
      endcase
      exp_half <= expect_half(m_model, x_model, b_model);
      @(posedge clk);
      cfg <= '0;
   endtask

   task automatic wait_ready();
      @(posedge clk);
      while (!uut.ready)
         @(posedge clk);
   endtask

   task automatic send_cmd(input logic [7:0] tx, input logic is_last);
      @(posedge clk);
      while (cmd_cred == 0)
         @(posedge clk);
      cmd       <= '{tx: tx, last: is_last};
      cmd_valid <= 1'b1;
      sent++;
      @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic send_burst(input int n, input logic end_last);
      for (int i = 0; i < n; i++)
         send_cmd(8'(lfsr_bits(stim_lfsr, 8)), end_last && (i == n - 1));
   endtask

   task automatic wait_drain();
      @(posedge clk);
      while (rsp_cnt != sent)
         @(posedge clk);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s: %0d errors", tests, name, err_cnt - last_err);
      last_err = err_cnt;
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   initial
   begin
      rst = 1'b1;
      cfg = '0;
      cmd = '0;
      cmd_valid = 1'b0;
      hold = 1'b0;
      run_end = 1'b0;
      stim_lfsr = 32'h92ab_ce7f;
      m_model = RST_SLOPE;
      x_model = RST_SPEED;
      b_model = RST_OFFSET;
      exp_half = expect_half(m_model, x_model, b_model);
      {sent, tests, last_err} = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      send_burst(4, 1'b1);  // reset timing
      wait_drain();
      end_test("reset half-period loopback");

      for (int k = 0; k < 5; k++)
      begin
         cfg_write(ADDR_SLOPE, lfsr_bits(stim_lfsr, 3));
         cfg_write(ADDR_SPEED, lfsr_bits(stim_lfsr, 4) % 10);
         cfg_write(ADDR_OFFSET, 1 + lfsr_bits(stim_lfsr, 3) % 6);
         wait_ready();
         send_burst(3, 1'b1);
         wait_drain();
      end
      end_test("random slope speed offset");

      // writes land while the long sum is still running
      cfg_write(ADDR_SLOPE, 32'd0);  // any stale sum stays below 7
      cfg_write(ADDR_SPEED, 32'd9);
      cfg_write(ADDR_SLOPE, 32'd3);
      cfg_write(2'd3, 32'hdead_beef);
      cfg_write(ADDR_OFFSET, 32'd2);
      wait_ready();
      send_burst(3, 1'b1);
      wait_drain();
      end_test("writes during calculation");

      send_burst(3, 1'b0);  // cs held low
      send_burst(3, 1'b1);
      wait_drain();
      end_test("chip select framing");

      // wait for every credit home before starving the engine
      while (uut.u_engine.rsp_cred != RSP_CNT_W'(RSP_CREDITS))
         @(posedge clk);
      hold <= 1'b1;
      base = rsp_cnt;
      send_burst(4, 1'b1);
      while (rsp_cnt < base + RSP_CREDITS)
         @(posedge clk);
      repeat (3 * ((2 * FRAME_W + 1) * int'(exp_half) + 8)) @(posedge clk);
      hold <= 1'b0;
      wait_drain();
      end_test("response credits withheld");

      for (int k = 0; k < 8; k++)
      begin
         tx_b   = 8'(lfsr_bits(stim_lfsr, 8));
         last_b = (k == 7) | (lfsr_bits(stim_lfsr, 1) != '0);
         send_cmd(tx_b, last_b);
      end
      wait_drain();
      run_end <= 1'b1;
      repeat (2) @(posedge clk);
      end_test("credit totals");

      $display("tests %0d, checks %0d, errors %0d", tests, chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("timeout: run still going after %0d clock cycles", WD_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: build.f
design/spi_cfg_pkg.sv
design/spi_xfer_pkg.sv
design/lin_calc.sv
design/spi_cfg_regs.sv
design/spi_shift_engine.sv
design/spi_master_top.sv
sim/spi_master_checker.sv
sim/spi_master_monitor.sv
sim/spi_master_tb.sv

// File: Makefile
# Verilator build and run for the spi master testbench

VERILATOR ?= verilator
TOP       ?= spi_master_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
